//--- logic/qbus_pkg.sv
package qbus_pkg;

   typedef logic [15:0] word_t;             // address, data and status word
   typedef logic [3:0]  virq_t;             // request levels 4 to 7

   typedef enum logic [2:0]
   {
      OP_READ       = 3'd0,
      OP_WRITE      = 3'd1,
      OP_WRITE_BYTE = 3'd2,
      OP_IACK       = 3'd3,
      OP_READ_SVC   = 3'd4,
      OP_CLR_EVNT   = 3'd5,
      OP_CLR_ACLO   = 3'd6
   } qbus_op_e;

   typedef enum logic [2:0]
   {
      ST_IDLE    = 3'd0,
      ST_ADDR    = 3'd1,
      ST_DATA    = 3'd2,
      ST_RELEASE = 3'd3,
      ST_DONE    = 3'd4
   } bus_state_e;

   localparam int SVC_EVNT_BIT = 12;        // timer event latch
   localparam int SVC_VIRQ_LSB = 8;         // virq levels in 11:8
   localparam int SVC_ACLO_BIT = 7;         // power-fail latch
   localparam int SVC_HALT_BIT = 5;
   localparam int SVC_TOUT_BIT = 4;         // last bus cycle timed out

   // operations that run a cycle on the bus, the rest are local
   function automatic logic is_bus_op(qbus_op_e op);
      return (op == OP_READ) | (op == OP_WRITE) | (op == OP_WRITE_BYTE) | (op == OP_IACK);
   endfunction

endpackage

//--- logic/bus_req_if.sv
`timescale 1ns/10ps

interface bus_req_if import qbus_pkg::*; ();
   logic     req_valid;                     // request held in decode
   qbus_op_e req_op;
   word_t    req_addr;
   word_t    req_wdata;
   logic     req_wtbt;                      // write status for address phase
   logic     req_bus;                       // needs a bus cycle
   logic     req_take;                      // cycle stage accepts request

   modport source
   (
      output req_valid, req_op, req_addr, req_wdata, req_wtbt, req_bus,
      input  req_take
   );

   modport sink
   (
      input  req_valid, req_op, req_addr, req_wdata, req_wtbt, req_bus,
      output req_take
   );
endinterface

//--- logic/bus_done_if.sv
`timescale 1ns/10ps

interface bus_done_if import qbus_pkg::*; ();
   logic     done_stb;                      // one clock per finished cycle
   qbus_op_e done_op;
   word_t    done_rdata;                    // din or iako data
   logic     done_tout;                     // no reply within timeout

   modport source
   (
      output done_stb, done_op, done_rdata, done_tout
   );

   // capture and status both listen on the same pulse
   modport sink
   (
      input  done_stb, done_op, done_rdata, done_tout
   );
endinterface

//--- logic/cmd_decode.sv
`timescale 1ns/10ps

module cmd_decode import qbus_pkg::*;
(
   input  logic      clk,
   input  logic      init,
   input  logic      cmd_stb,
   input  qbus_op_e  cmd_op,
   input  word_t     cmd_addr,
   input  word_t     cmd_wdata,
   output logic      busy,
   bus_req_if.source req
);

   logic accept;                            // command taken this clock

   // entry leaving this clock frees the slot for a new command
   assign busy   = req.req_valid & ~req.req_take;
   assign accept = cmd_stb & ~busy;

   always_ff @(posedge clk or posedge init)
   begin
      if (init)
         req.req_valid <= 1'b0;
      else if (accept)
         req.req_valid <= 1'b1;
      else if (req.req_take)
         req.req_valid <= 1'b0;             // handed to bus cycle
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req.req_op    <= cmd_op;
         req.req_addr  <= cmd_addr;
         req.req_wdata <= cmd_wdata;
         req.req_wtbt  <= (cmd_op == OP_WRITE) | (cmd_op == OP_WRITE_BYTE);
         req.req_bus   <= is_bus_op(cmd_op);
      end
   end

endmodule

//--- logic/bus_cycle.sv
`timescale 1ns/10ps

module bus_cycle import qbus_pkg::*;
#(
   parameter int ADDR_CLK    = 2,
   parameter int TIMEOUT_CLK = 64
)
(
   input  logic       clk,
   input  logic       init,
   bus_req_if.sink    req,
   bus_done_if.source done,
   output word_t      bus_ad_out,
   output logic       bus_ad_oe,
   input  word_t      bus_ad_in,
   output logic       bus_sync,
   output logic       bus_din,
   output logic       bus_dout,
   output logic       bus_iako,
   output logic       bus_wtbt,
   input  logic       bus_rply
);

   localparam int CNT_MAX = (TIMEOUT_CLK > ADDR_CLK) ? TIMEOUT_CLK : ADDR_CLK;
   localparam int CNT_W   = $clog2(CNT_MAX) + 1;

   bus_state_e       state;
   logic [CNT_W-1:0] cnt;                   // address hold, then timeout
   logic             rply_meta;
   logic             rply_s;                // synchronized reply
   logic             tout_r;
   qbus_op_e         op_r;
   word_t            addr_r;
   word_t            wdata_r;
   word_t            rdata_r;
   logic             wtbt_r;
   logic             in_addr;
   logic             in_data;

   assign in_addr = (state == ST_ADDR);
   assign in_data = (state == ST_DATA);

   assign req.req_take = (state == ST_IDLE);

   assign bus_sync   = in_data | (state == ST_RELEASE);
   assign bus_din    = in_data & (op_r == OP_READ);
   assign bus_dout   = in_data & wtbt_r;
   assign bus_iako   = in_data & (op_r == OP_IACK);
   assign bus_ad_oe  = in_addr | bus_dout;
   assign bus_ad_out = in_addr ? addr_r : wdata_r;
   assign bus_wtbt   = in_addr ? wtbt_r : bus_dout & (op_r == OP_WRITE_BYTE); // byte in data phase

   assign done.done_stb   = (state == ST_DONE);
   assign done.done_op    = op_r;
   assign done.done_rdata = rdata_r;
   assign done.done_tout  = tout_r;

   always_ff @(posedge clk or posedge init)
   begin
      if (init)
      begin
         rply_meta <= 1'b0;
         rply_s    <= 1'b0;
      end
      else
      begin
         rply_meta <= bus_rply;             // two-flop chain
         rply_s    <= rply_meta;
      end
   end

   always_ff @(posedge clk or posedge init)
   begin
      if (init)
      begin
         state  <= ST_IDLE;
         cnt    <= '0;
         tout_r <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (req.req_valid)
               begin
                  cnt    <= '0;
                  tout_r <= 1'b0;
                  state  <= req.req_bus ? ST_ADDR : ST_DONE;
               end
            ST_ADDR:
               if (cnt == CNT_W'(ADDR_CLK - 1))
               begin
                  cnt   <= '0;
                  state <= ST_DATA;         // sync rises here
               end
               else
                  cnt <= cnt + 1'b1;
            ST_DATA:
               if (rply_s)
                  state <= ST_RELEASE;
               else if (cnt == CNT_W'(TIMEOUT_CLK - 1))
               begin
                  tout_r <= 1'b1;
                  state  <= ST_RELEASE;
               end
               else
                  cnt <= cnt + 1'b1;
            ST_RELEASE:
               if (tout_r | ~rply_s)        // slave removed reply
                  state <= ST_DONE;
            ST_DONE:
               state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (req.req_take & req.req_valid)
      begin
         op_r    <= req.req_op;
         addr_r  <= req.req_addr;
         wdata_r <= req.req_wdata;
         wtbt_r  <= req.req_wtbt;
      end
      if (in_data & rply_s)
         rdata_r <= bus_ad_in;              // din or vector data
   end

endmodule

//--- logic/svc_status.sv
`timescale 1ns/10ps

module svc_status import qbus_pkg::*;
(
   input  logic     clk,
   input  logic     init,
   input  logic     evnt_n,
   input  logic     aclo_n,
   input  virq_t    virq,
   input  logic     halt,
   bus_done_if.sink done,
   output word_t    svc_word
);

   localparam logic [6:0] IN_IDLE = 7'b1100000; // evnt_n and aclo_n idle high

   logic [6:0] in_meta;
   logic [6:0] in_sync;                     // {evnt_n, aclo_n, halt, virq}
   logic       evnt_prev;
   logic       aclo_prev;
   logic       evnt_lat;
   logic       aclo_lat;
   logic       tout_lat;

   always_ff @(posedge clk or posedge init)
   begin
      if (init)
      begin
         in_meta   <= IN_IDLE;
         in_sync   <= IN_IDLE;
         evnt_prev <= 1'b1;
         aclo_prev <= 1'b1;
      end
      else
      begin
         in_meta   <= {evnt_n, aclo_n, halt, virq};
         in_sync   <= in_meta;
         evnt_prev <= in_sync[6];           // for falling edge detect
         aclo_prev <= in_sync[5];
      end
   end

   always_ff @(posedge clk or posedge init)
   begin
      if (init)
      begin
         evnt_lat <= 1'b0;
         aclo_lat <= 1'b0;
         tout_lat <= 1'b0;
      end
      else
      begin
         if (evnt_prev & ~in_sync[6])
            evnt_lat <= 1'b1;               // new edge wins over clear
         else if (done.done_stb && done.done_op == OP_CLR_EVNT)
            evnt_lat <= 1'b0;
         if (aclo_prev & ~in_sync[5])
            aclo_lat <= 1'b1;
         else if (done.done_stb && done.done_op == OP_CLR_ACLO)
            aclo_lat <= 1'b0;
         if (done.done_stb && is_bus_op(done.done_op))
            tout_lat <= done.done_tout;     // result of last bus cycle
      end
   end

   always_comb
   begin
      svc_word                    = '0;
      svc_word[SVC_EVNT_BIT]      = evnt_lat;
      svc_word[SVC_VIRQ_LSB +: 4] = in_sync[3:0];
      svc_word[SVC_ACLO_BIT]      = aclo_lat;
      svc_word[SVC_HALT_BIT]      = in_sync[4];
      svc_word[SVC_TOUT_BIT]      = tout_lat;
   end

endmodule

//--- logic/reply_capture.sv
`timescale 1ns/10ps

module reply_capture import qbus_pkg::*;
(
   input  logic     clk,
   input  logic     init,
   bus_done_if.sink done,
   input  word_t    svc_word,
   output logic     rsp_stb,
   output word_t    rsp_data,
   output logic     rsp_err
);

   always_ff @(posedge clk or posedge init)
   begin
      if (init)
         rsp_stb <= 1'b0;
      else
         rsp_stb <= done.done_stb;          // one clock behind done
   end

   // svc_word here is still the value from before this done pulse
   always_ff @(posedge clk)
   begin
      if (done.done_stb)
      begin
         case (done.done_op)
            OP_READ, OP_IACK: rsp_data <= done.done_rdata;
            OP_READ_SVC:      rsp_data <= svc_word;
            default:          rsp_data <= '0;   // writes and clears
         endcase
         rsp_err <= done.done_tout;
      end
   end

endmodule

//--- logic/qbus_master.sv
`timescale 1ns/10ps

module qbus_master import qbus_pkg::*;
#(
   parameter int ADDR_CLK    = 2,           // address hold before sync
   parameter int TIMEOUT_CLK = 64           // data phase reply limit
)
(
   input  logic     clk,
   input  logic     init,
   input  logic     cmd_stb,
   input  qbus_op_e cmd_op,
   input  word_t    cmd_addr,
   input  word_t    cmd_wdata,
   output logic     busy,
   output logic     rsp_stb,
   output word_t    rsp_data,
   output logic     rsp_err,
   output word_t    bus_ad_out,
   output logic     bus_ad_oe,
   input  word_t    bus_ad_in,
   output logic     bus_sync,
   output logic     bus_din,
   output logic     bus_dout,
   output logic     bus_wtbt,
   output logic     bus_iako,
   input  logic     bus_rply,
   input  logic     evnt_n,
   input  logic     aclo_n,
   input  virq_t    virq,
   input  logic     halt
);

   word_t svc_word;                         // status word into capture

   bus_req_if  req_if ();
   bus_done_if done_if ();

   cmd_decode cmd_decode_i
   (
      .clk       (clk),
      .init      (init),
      .cmd_stb   (cmd_stb),
      .cmd_op    (cmd_op),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .busy      (busy),
      .req       (req_if.source)
   );

   bus_cycle #(.ADDR_CLK(ADDR_CLK), .TIMEOUT_CLK(TIMEOUT_CLK)) bus_cycle_i
   (
      .clk        (clk),
      .init       (init),
      .req        (req_if.sink),
      .done       (done_if.source),
      .bus_ad_out (bus_ad_out),
      .bus_ad_oe  (bus_ad_oe),
      .bus_ad_in  (bus_ad_in),
      .bus_sync   (bus_sync),
      .bus_din    (bus_din),
      .bus_dout   (bus_dout),
      .bus_iako   (bus_iako),
      .bus_wtbt   (bus_wtbt),
      .bus_rply   (bus_rply)
   );

   svc_status svc_status_i
   (
      .clk      (clk),
      .init     (init),
      .evnt_n   (evnt_n),
      .aclo_n   (aclo_n),
      .virq     (virq),
      .halt     (halt),
      .done     (done_if.sink),
      .svc_word (svc_word)
   );

   reply_capture reply_capture_i
   (
      .clk      (clk),
      .init     (init),
      .done     (done_if.sink),
      .svc_word (svc_word),
      .rsp_stb  (rsp_stb),
      .rsp_data (rsp_data),
      .rsp_err  (rsp_err)
   );

endmodule

//--- testbench/qbus_slave_model.sv
`timescale 1ns/10ps

module qbus_slave_model import qbus_pkg::*;
#(
   parameter word_t IACK_VECTOR = 16'o300
)
(
   input  logic  clk,
   input  logic  init,
   input  word_t bus_ad_out,
   input  logic  bus_ad_oe,
   output word_t bus_ad_in,
   input  logic  bus_sync,
   input  logic  bus_din,
   input  logic  bus_dout,
   input  logic  bus_wtbt,
   input  logic  bus_iako,
   output logic  bus_rply
);

   word_t mem [word_t];                     // written words only
   word_t addr_lat;                         // address from the address phase
   word_t old_word;
   logic  wait_cnt;
   logic  strobe;

   assign strobe = bus_din | bus_dout | bus_iako;

   // unwritten words read back as the inverted address
   function automatic word_t read_word(input word_t addr);
      if (mem.exists(addr))
         return mem[addr];
      return ~addr;
   endfunction

   always @(posedge clk or posedge init)
   begin
      if (init)
      begin
         bus_rply  <= 1'b0;
         bus_ad_in <= '0;
         wait_cnt  <= 1'b0;
         addr_lat  <= '0;
      end
      else
      begin
         if (bus_ad_oe & ~bus_sync)
            addr_lat <= bus_ad_out;
         if (~strobe)
         begin
            bus_rply <= 1'b0;               // reply follows the strobe down
            wait_cnt <= 1'b0;
         end
         else if (addr_lat[15:13] != 3'b111 && !bus_rply)
         begin
            if (!wait_cnt)
               wait_cnt <= 1'b1;
            else
            begin
               bus_rply <= 1'b1;
               if (bus_din)
                  bus_ad_in <= read_word(addr_lat);
               if (bus_iako)
                  bus_ad_in <= IACK_VECTOR;
               if (bus_dout)
               begin
                  old_word = read_word(addr_lat);
                  if (bus_wtbt)
                     mem[addr_lat] = {old_word[15:8], bus_ad_out[7:0]}; // low byte only
                  else
                     mem[addr_lat] = bus_ad_out;
               end
            end
         end
      end
   end

endmodule

//--- testbench/tb_qbus_master.sv
`timescale 1ns/10ps

module tb_qbus_master import qbus_pkg::*; ();

   localparam int ADDR_CLK    = 2;
   localparam int TIMEOUT_CLK = 64;
   localparam int RESET_CLK   = 5;
   localparam int WAIT_LIMIT  = TIMEOUT_CLK + 20;   // clocks per command

   logic     clk;
   logic     init;
   logic     cmd_stb;
   qbus_op_e cmd_op;
   word_t    cmd_addr;
   word_t    cmd_wdata;
   logic     busy;
   logic     rsp_stb;
   word_t    rsp_data;
   logic     rsp_err;
   word_t    bus_ad_out;
   logic     bus_ad_oe;
   word_t    bus_ad_in;
   logic     bus_sync;
   logic     bus_din;
   logic     bus_dout;
   logic     bus_wtbt;
   logic     bus_iako;
   logic     bus_rply;
   logic     evnt_n;
   logic     aclo_n;
   virq_t    virq;
   logic     halt;

   string    name_q[$];
   qbus_op_e op_q[$];
   word_t    addr_q[$];
   word_t    wdata_q[$];
   virq_t    virq_q[$];
   logic     halt_q[$];
   logic     evnt_q[$];
   logic     aclo_q[$];
   word_t    expd_q[$];
   logic     experr_q[$];
   logic     tests_loaded = 1'b0;

   qbus_master #(.ADDR_CLK(ADDR_CLK), .TIMEOUT_CLK(TIMEOUT_CLK)) qbus_master_i
   (
      .clk(clk), .init(init), .cmd_stb(cmd_stb), .cmd_op(cmd_op),
      .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .busy(busy),
      .rsp_stb(rsp_stb), .rsp_data(rsp_data), .rsp_err(rsp_err),
      .bus_ad_out(bus_ad_out), .bus_ad_oe(bus_ad_oe), .bus_ad_in(bus_ad_in),
      .bus_sync(bus_sync), .bus_din(bus_din), .bus_dout(bus_dout),
      .bus_wtbt(bus_wtbt), .bus_iako(bus_iako), .bus_rply(bus_rply),
      .evnt_n(evnt_n), .aclo_n(aclo_n), .virq(virq), .halt(halt)
   );

   qbus_slave_model qbus_slave_model_i
   (
      .clk(clk), .init(init), .bus_ad_out(bus_ad_out), .bus_ad_oe(bus_ad_oe),
      .bus_ad_in(bus_ad_in), .bus_sync(bus_sync), .bus_din(bus_din),
      .bus_dout(bus_dout), .bus_wtbt(bus_wtbt), .bus_iako(bus_iako),
      .bus_rply(bus_rply)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string test, input string what, input word_t expected,
                              input word_t actual);
      assert (actual === expected)
      else
         stop_with_failure($sformatf("[ERROR] %s: %s expected %h, actual %h",
                                     test, what, expected, actual));
   endtask

   task automatic step_clock();
      @(posedge clk);
      #1;                                   // drive and sample after the edge
   endtask

   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      string       name;
      string       opname;
      qbus_op_e    op;
      logic [15:0] f_addr;
      logic [15:0] f_wdata;
      logic [15:0] f_expd;
      logic [3:0]  f_virq;
      logic        f_halt;
      logic        f_evnt;
      logic        f_aclo;
      logic        f_err;
      fd = $fopen("testbench/qbus_stimulus.txt", "r");
      if (fd == 0)
         stop_with_failure("cannot open testbench/qbus_stimulus.txt");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line.getc(0) == "#")
            continue;                       // blank or column notes
         n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", name, opname, f_addr,
                     f_wdata, f_virq, f_halt, f_evnt, f_aclo, f_expd, f_err);
         if (n != 10)
            stop_with_failure({"malformed stimulus line: ", line});
         case (opname)
            "READ":       op = OP_READ;
            "WRITE":      op = OP_WRITE;
            "WRITE_BYTE": op = OP_WRITE_BYTE;
            "IACK":       op = OP_IACK;
            "READ_SVC":   op = OP_READ_SVC;
            "CLR_EVNT":   op = OP_CLR_EVNT;
            "CLR_ACLO":   op = OP_CLR_ACLO;
            default:      stop_with_failure({"unknown operation in stimulus: ", opname});
         endcase
         name_q.push_back(name);
         op_q.push_back(op);
         addr_q.push_back(f_addr);
         wdata_q.push_back(f_wdata);
         virq_q.push_back(f_virq);
         halt_q.push_back(f_halt);
         evnt_q.push_back(f_evnt);
         aclo_q.push_back(f_aclo);
         expd_q.push_back(f_expd);
         experr_q.push_back(f_err);
      end
      $fclose(fd);
      if (name_q.size() == 0)
         stop_with_failure("stimulus file holds no tests");
      tests_loaded = 1'b1;
   endtask

   task automatic run_test(input int idx);
      int waited;
      virq = virq_q[idx];
      halt = halt_q[idx];
      evnt_n = ~evnt_q[idx];                // pulse low when requested
      aclo_n = ~aclo_q[idx];
      repeat (3) step_clock();
      evnt_n = 1'b1;
      aclo_n = 1'b1;
      repeat (4) step_clock();              // let the input synchronizers settle
      waited = 0;
      while (busy)
      begin
         step_clock();
         waited++;
         if (waited > WAIT_LIMIT)
            stop_with_failure({"busy stayed high before test ", name_q[idx]});
      end
      cmd_stb   = 1'b1;
      cmd_op    = op_q[idx];
      cmd_addr  = addr_q[idx];
      cmd_wdata = wdata_q[idx];
      step_clock();
      cmd_stb = 1'b0;
      check_value(name_q[idx], "busy", 16'h0000, word_t'(busy)); // idle bus stage takes it at once
      waited = 0;
      while (!rsp_stb)
      begin
         step_clock();
         waited++;
         if (waited > WAIT_LIMIT)
            stop_with_failure({"no response strobe in test ", name_q[idx]});
      end
      check_value(name_q[idx], "rsp_err", word_t'(experr_q[idx]), word_t'(rsp_err));
      if (!experr_q[idx])
         check_value(name_q[idx], "rsp_data", expd_q[idx], rsp_data); // undefined on timeout
   endtask

   // limit grows with the number of commands in the file
   initial
   begin
      wait (tests_loaded);
      repeat (RESET_CLK + name_q.size() * (TIMEOUT_CLK + 20)) @(posedge clk);
      stop_with_failure($sformatf("watchdog expired, %0d tests did not finish in time",
                                  name_q.size()));
   end

   initial
   begin
      int idx;
      init      = 1'b1;
      cmd_stb   = 1'b0;
      cmd_op    = OP_READ;
      cmd_addr  = '0;
      cmd_wdata = '0;
      evnt_n    = 1'b1;
      aclo_n    = 1'b1;
      virq      = '0;
      halt      = 1'b0;
      load_tests();
      repeat (RESET_CLK) @(posedge clk);
      #1 init = 1'b0;
      for (idx = 0; idx < name_q.size(); idx++)
         run_test(idx);
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- qbus_master.f
logic/qbus_pkg.sv
logic/bus_req_if.sv
logic/bus_done_if.sv
logic/cmd_decode.sv
logic/bus_cycle.sv
logic/svc_status.sv
logic/reply_capture.sv
logic/qbus_master.sv
testbench/qbus_slave_model.sv
testbench/tb_qbus_master.sv

//--- testbench/qbus_stimulus.txt
# name op addr wdata virq halt evnt aclo exp_data exp_err (hex; evnt/aclo 1 = pulse before command)
# exp_data is not compared on rows that expect a timeout error
wr_a       WRITE      1000 1234 0 0 0 0 0000 0
rd_a       READ       1000 0000 0 0 0 0 1234 0
rd_blank   READ       0200 0000 0 0 0 0 fdff 0
wr_b       WRITE      2002 a5c3 0 0 0 0 0000 0
wrb_b      WRITE_BYTE 2002 be77 0 0 0 0 0000 0
rd_b       READ       2002 0000 0 0 0 0 a577 0
wrb_c      WRITE_BYTE 3004 1122 0 0 0 0 0000 0
rd_c       READ       3004 0000 0 0 0 0 cf22 0
rd_norply  READ       e000 0000 0 0 0 0 0000 1
svc_tout   READ_SVC   0000 0000 0 0 0 0 0010 0
wr_clear   WRITE      1000 4321 0 0 0 0 0000 0
svc_ok     READ_SVC   0000 0000 0 0 0 0 0000 0
iack       IACK       0000 0000 0 0 0 0 00c0 0
svc_all    READ_SVC   0000 0000 a 1 1 1 1aa0 0
clr_evnt   CLR_EVNT   0000 0000 a 1 0 0 0000 0
clr_aclo   CLR_ACLO   0000 0000 a 1 0 0 0000 0
svc_clr    READ_SVC   0000 0000 a 1 0 0 0a20 0
svc_lvl    READ_SVC   0000 0000 5 0 0 0 0500 0
rd_last    READ       1000 0000 0 0 0 0 4321 0
